// File: compile.f
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/rv_mini_core.sv
dv/tb_rv_mini_core.sv

// File: dv/tb_rv_mini_core.sv
/*
  Testbench for the mini core. An instruction memory model with random grant
  delay serves a hand-assembled program, and every retirement is checked in order.
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module tb_rv_mini_core;
  import pipe_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int PROG_WORDS  = 26;
  localparam int NUM_RETIRES = 20;
  localparam logic [`CORE_XLEN-1:0] BOOT_ADDR = 32'h0000_1000;

  logic                  clk;
  logic                  rst_n;
  logic [`CORE_XLEN-1:0] boot_addr;
  logic                  instr_req;
  logic                  instr_gnt;
  logic                  instr_rvalid;
  logic [`CORE_XLEN-1:0] instr_addr;
  logic [31:0]           instr_rdata;
  retire_t               retire;

  // Program image, word 0 sits at the boot address
  logic [31:0] program_words [PROG_WORDS];
  // Expected retirements, in order
  string       exp_name [NUM_RETIRES];
  logic [31:0] exp_pc   [NUM_RETIRES];
  logic        exp_we   [NUM_RETIRES];
  logic [4:0]  exp_rd   [NUM_RETIRES];
  logic [31:0] exp_data [NUM_RETIRES];
  int          exp_count;
  int          checked_count;
  int          pass_count;
  int          fail_count;
  logic [31:0] first_gnt_addr;
  logic        first_gnt_seen;

  rv_mini_core rv_mini_core_inst (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .boot_addr_i    (boot_addr),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .retire_o       (retire)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Program and expected tables

  task automatic load_program();
    // ADDI x1,x0,5 / ADD x2,x1,x1 / SUB x3,x1,x2 / LUI x4,0x12345
    program_words[0]  = 32'h0050_0093;
    program_words[1]  = 32'h0010_8133;
    program_words[2]  = 32'h4020_81B3;
    program_words[3]  = 32'h1234_5237;
    // ADDI x5,x0,-1 / AND x6,x4,x5 / OR x7,x1,x4 / XOR x8,x7,x5
    program_words[4]  = 32'hFFF0_0293;
    program_words[5]  = 32'h0052_7333;
    program_words[6]  = 32'h0040_E3B3;
    program_words[7]  = 32'h0053_C433;
    // ADDI x0,x1,7 then ADD x9,x0,x1
    program_words[8]  = 32'h0070_8013;
    program_words[9]  = 32'h0010_04B3;
    // BEQ x1,x3,+8 and BNE x1,x9,+12, both fall through
    program_words[10] = 32'h0030_8463;
    program_words[11] = 32'h0090_9663;
    // BEQ x1,x9,+12 taken, skips two ADDI x10
    program_words[12] = 32'h0090_8663;
    program_words[13] = 32'h0010_0513;
    program_words[14] = 32'h0020_0513;
    // BNE x2,x1,+12 taken, skips two ADDI x11
    program_words[15] = 32'h0011_1663;
    program_words[16] = 32'h0010_0593;
    program_words[17] = 32'h0020_0593;
    // JAL x12,+12, skips two ADDI x13
    program_words[18] = 32'h00C0_066F;
    program_words[19] = 32'h0010_0693;
    program_words[20] = 32'h0020_0693;
    // Custom-0 opcode shaped like ADDI x1,x0,-1
    program_words[21] = 32'hFFF0_008B;
    // ADD x14,x1,x0 / ADD x15,x12,x0 / OR x16,x10,x11 / ADD x17,x13,x0
    program_words[22] = 32'h0000_8733;
    program_words[23] = 32'h0006_07B3;
    program_words[24] = 32'h00B5_6833;
    program_words[25] = 32'h0006_88B3;
  endtask

  task automatic add_expect(input string name, input logic [31:0] pc, input logic we,
                            input logic [4:0] rd, input logic [31:0] data);
    exp_name[exp_count] = name;
    exp_pc[exp_count]   = pc;
    exp_we[exp_count]   = we;
    exp_rd[exp_count]   = rd;
    exp_data[exp_count] = data;
    exp_count++;
  endtask

  task automatic load_expected();
    exp_count = 0;
    add_expect("boot_addi_x1",     32'h1000, 1'b1, 5'd1,  32'h0000_0005);
    add_expect("add_dep_x2",       32'h1004, 1'b1, 5'd2,  32'h0000_000A);
    add_expect("sub_neg_x3",       32'h1008, 1'b1, 5'd3,  32'hFFFF_FFFB);
    add_expect("lui_x4",           32'h100C, 1'b1, 5'd4,  32'h1234_5000);
    add_expect("addi_neg_x5",      32'h1010, 1'b1, 5'd5,  32'hFFFF_FFFF);
    add_expect("and_x6",           32'h1014, 1'b1, 5'd6,  32'h1234_5000);
    add_expect("or_x7",            32'h1018, 1'b1, 5'd7,  32'h1234_5005);
    add_expect("xor_x8",           32'h101C, 1'b1, 5'd8,  32'hEDCB_AFFA);
    add_expect("addi_to_x0",       32'h1020, 1'b1, 5'd0,  32'h0000_000C);
    add_expect("x0_reads_zero",    32'h1024, 1'b1, 5'd9,  32'h0000_0005);
    add_expect("beq_not_taken",    32'h1028, 1'b0, 5'd0,  32'h0000_0000);
    add_expect("bne_not_taken",    32'h102C, 1'b0, 5'd0,  32'h0000_0000);
    add_expect("beq_taken",        32'h1030, 1'b0, 5'd0,  32'h0000_0000);
    // Target of the BEQ, both skipped words gone
    add_expect("bne_taken",        32'h103C, 1'b0, 5'd0,  32'h0000_0000);
    add_expect("jal_link",         32'h1048, 1'b1, 5'd12, 32'h0000_104C);
    add_expect("unknown_opcode",   32'h1054, 1'b0, 5'd0,  32'h0000_0000);
    add_expect("x1_unchanged",     32'h1058, 1'b1, 5'd14, 32'h0000_0005);
    add_expect("jal_link_reg",     32'h105C, 1'b1, 5'd15, 32'h0000_104C);
    add_expect("skipped_x10_x11",  32'h1060, 1'b1, 5'd16, 32'h0000_0000);
    add_expect("skipped_x13",      32'h1064, 1'b1, 5'd17, 32'h0000_0000);
  endtask

  // Unlisted addresses read as NOP
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] index;
    index = (addr - BOOT_ADDR) >> 2;
    if (index < PROG_WORDS) begin
      return program_words[index];
    end else begin
      return `CORE_NOP_INSTR;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Instruction memory model, grant after 0 to 3 cycles, data one cycle later

  initial begin : memory_model
    int unsigned delay;
    logic        waiting;
    logic        respond;
    logic [31:0] gnt_addr;
    void'($urandom(40));
    delay    = 0;
    waiting  = 1'b0;
    respond  = 1'b0;
    gnt_addr = '0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      instr_gnt    = 1'b0;
      instr_rvalid = 1'b0;
      if (respond) begin
        instr_rvalid = 1'b1;
        instr_rdata  = fetch_word(gnt_addr);
        respond      = 1'b0;
      end else if (instr_req) begin
        if (!waiting) begin
          delay   = $urandom_range(3, 0);
          waiting = 1'b1;
        end
        if (delay == 0) begin
          instr_gnt = 1'b1;
          gnt_addr  = instr_addr;
          respond   = 1'b1;
          waiting   = 1'b0;
          if (!first_gnt_seen) begin
            first_gnt_addr = instr_addr;
            first_gnt_seen = 1'b1;
          end
        end else begin
          delay = delay - 1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  task automatic check_retire(input int idx);
    logic ok;
    ok = 1'b1;
    if (retire.pc !== exp_pc[idx]) begin
      $display("CHECK FAILED %s pc: expected %h, actual %h", exp_name[idx], exp_pc[idx],
               retire.pc);
      ok = 1'b0;
    end
    if (retire.we !== exp_we[idx]) begin
      $display("CHECK FAILED %s we: expected %b, actual %b", exp_name[idx], exp_we[idx],
               retire.we);
      ok = 1'b0;
    end
    // Destination and data matter only for a register write
    if (exp_we[idx]) begin
      if (retire.rd !== exp_rd[idx]) begin
        $display("CHECK FAILED %s rd: expected %0d, actual %0d", exp_name[idx], exp_rd[idx],
                 retire.rd);
        ok = 1'b0;
      end
      if (retire.data !== exp_data[idx]) begin
        $display("CHECK FAILED %s data: expected %h, actual %h", exp_name[idx],
                 exp_data[idx], retire.data);
        ok = 1'b0;
      end
    end
    if (ok) begin
      pass_count++;
      $display("test %-16s ok", exp_name[idx]);
    end else begin
      fail_count++;
      $display("test %-16s failed", exp_name[idx]);
    end
  endtask

  task automatic check_boot_fetch();
    if (!first_gnt_seen) begin
      $display("No instruction fetch was ever granted");
      fail_count++;
      $display("test %-16s failed", "boot_fetch");
    end else if (first_gnt_addr !== BOOT_ADDR) begin
      $display("CHECK FAILED boot_fetch addr: expected %h, actual %h", BOOT_ADDR,
               first_gnt_addr);
      fail_count++;
      $display("test %-16s failed", "boot_fetch");
    end else begin
      pass_count++;
      $display("test %-16s ok", "boot_fetch");
    end
  endtask

  // Budget of 40 cycles per expected retirement
  initial begin : watchdog
    #(CLK_PERIOD * 40 * NUM_RETIRES);
    $display("Timeout: %0d of %0d retirements seen before the time limit", checked_count,
             NUM_RETIRES);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    rst_n          = 1'b0;
    boot_addr      = BOOT_ADDR;
    instr_gnt      = 1'b0;
    instr_rvalid   = 1'b0;
    instr_rdata    = '0;
    first_gnt_addr = '0;
    first_gnt_seen = 1'b0;
    checked_count  = 0;
    pass_count     = 0;
    fail_count     = 0;
    load_program();
    load_expected();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Retire outputs settle after the rising edge
    for (int i = 0; i < NUM_RETIRES; i++) begin
      @(negedge clk);
      while (retire.valid !== 1'b1) begin
        @(negedge clk);
      end
      check_retire(i);
      checked_count++;
    end
    check_boot_fetch();
    $display("Tests: %0d run, %0d passed, %0d failed", pass_count + fail_count, pass_count,
             fail_count);
    if (fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/rv_mini_core.sv
/*
  Top level of the three-stage RV32I mini core: fetch, decode, execute and
  the register file. Instruction memory strobes in, one retire report out.
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module rv_mini_core (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`CORE_XLEN-1:0] boot_addr_i,
  // Instruction memory
  output logic                  instr_req_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  output logic [`CORE_XLEN-1:0] instr_addr_o,
  input  logic [31:0]           instr_rdata_i,
  // Retired instructions, in order
  output pipe_pkg::retire_t     retire_o
);
  import pipe_pkg::*;

  if_id_t                      if_id;
  id_ex_t                      id_ex;
  // Taken branch or JAL, flushes fetch and decode
  redirect_t                   redirect;
  logic [`CORE_REG_ADDR_W-1:0] rs1_addr;
  logic [`CORE_REG_ADDR_W-1:0] rs2_addr;
  logic [`CORE_XLEN-1:0]       rs1_data;
  logic [`CORE_XLEN-1:0]       rs2_data;
  // Execute write port, also the bypass
  logic                        rf_we;
  logic [`CORE_REG_ADDR_W-1:0] rf_waddr;
  logic [`CORE_XLEN-1:0]       rf_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch
  fetch_stage fetch_stage_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .redirect_i     (redirect),
    .if_id_o        (if_id)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  decode_stage decode_stage_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .if_id_i    (if_id),
    .redirect_i (redirect),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .fwd_we_i   (rf_we),
    .fwd_rd_i   (rf_waddr),
    .fwd_data_i (rf_wdata),
    .id_ex_o    (id_ex)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute
  execute_stage execute_stage_inst (
    .id_ex_i    (id_ex),
    .redirect_o (redirect),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .retire_o   (retire_o)
  );

  // Read in decode, written from execute
  register_file register_file_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

endmodule

`default_nettype wire

// File: design/execute_stage.sv
/*
  Execute: ALU, branch compare and JAL link. Drives the redirect to fetch and
  decode, the register-file write port and the retire report.
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module execute_stage (
  input  pipe_pkg::id_ex_t            id_ex_i,
  output pipe_pkg::redirect_t         redirect_o,
  // Register file write port and decode bypass
  output logic                        rf_we_o,
  output logic [`CORE_REG_ADDR_W-1:0] rf_waddr_o,
  output logic [`CORE_XLEN-1:0]       rf_wdata_o,
  output pipe_pkg::retire_t           retire_o
);
  import isa_pkg::*;

  logic [`CORE_XLEN-1:0] alu_result;
  logic [`CORE_XLEN-1:0] link_addr;
  logic [`CORE_XLEN-1:0] result;
  logic                  operands_equal;
  logic                  branch_taken;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
      ALU_SUB:    alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_AND:    alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      ALU_OR:     alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_XOR:    alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      // LUI
      ALU_PASS_B: alu_result = id_ex_i.operand_b;
      default:    alu_result = '0;
    endcase
  end

  // JAL writes the return address
  assign link_addr = id_ex_i.pc + `CORE_XLEN'd4;
  assign result    = id_ex_i.is_jal ? link_addr : alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // Branch decision
  assign operands_equal = (id_ex_i.operand_a == id_ex_i.operand_b);
  // BEQ takes on equal and BNE on not equal
  assign branch_taken   = id_ex_i.is_branch && (operands_equal != id_ex_i.branch_ne);

  assign redirect_o = '{
    valid:  id_ex_i.valid && (branch_taken || id_ex_i.is_jal),
    target: id_ex_i.pc + id_ex_i.immediate
  };

  assign rf_we_o    = id_ex_i.valid && id_ex_i.reg_we;
  assign rf_waddr_o = id_ex_i.rd;
  assign rf_wdata_o = result;

  assign retire_o = '{
    valid: id_ex_i.valid,
    pc:    id_ex_i.pc,
    rd:    id_ex_i.rd,
    we:    id_ex_i.reg_we,
    data:  result
  };

  // Branches reach execute without a write enable
  a_branch_no_write: assert final (!(id_ex_i.valid && id_ex_i.is_branch && id_ex_i.reg_we));

endmodule

`default_nettype wire

// File: design/decode_stage.sv
/*
  Decode: splits the fetched word through its R and I views, builds the
  immediate, reads and forwards operands, and fills the decode/execute register.
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module decode_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  pipe_pkg::if_id_t            if_id_i,
  input  pipe_pkg::redirect_t         redirect_i,
  // Register file read
  output logic [`CORE_REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`CORE_REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [`CORE_XLEN-1:0]       rs1_data_i,
  input  logic [`CORE_XLEN-1:0]       rs2_data_i,
  // Execute write, fed back
  input  logic                        fwd_we_i,
  input  logic [`CORE_REG_ADDR_W-1:0] fwd_rd_i,
  input  logic [`CORE_XLEN-1:0]       fwd_data_i,
  output pipe_pkg::id_ex_t            id_ex_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  instr_u                instr;
  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_u;
  logic [`CORE_XLEN-1:0] imm_b;
  logic [`CORE_XLEN-1:0] imm_j;
  logic [`CORE_XLEN-1:0] rs1_val;
  logic [`CORE_XLEN-1:0] rs2_val;
  id_ex_t                id_ex_d;
  id_ex_t                id_ex_q;

  // Empty slot decodes as NOP
  assign instr = if_id_i.valid ? if_id_i.instr : instr_u'(`CORE_NOP_INSTR);

  ////////////////////////////////////////////////////////////////////////////
  // Immediates, all bits taken from the I view
  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_u = {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'b0};
  // B: imm[12|10:5] in imm field, imm[4:1|11] in rd field
  assign imm_b = {{20{instr.i.imm[11]}}, instr.i.rd[0], instr.i.imm[10:5],
                  instr.i.rd[4:1], 1'b0};
  // J: imm[19:12] sits in rs1 and funct3
  assign imm_j = {{12{instr.i.imm[11]}}, instr.i.rs1, instr.i.funct3,
                  instr.i.imm[0], instr.i.imm[10:1], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Register read with bypass from execute
  assign rs1_addr_o = instr.r.rs1;
  assign rs2_addr_o = instr.r.rs2;

  // x0 never bypassed
  assign rs1_val = (fwd_we_i && fwd_rd_i != '0 && fwd_rd_i == instr.r.rs1) ?
                   fwd_data_i : rs1_data_i;
  assign rs2_val = (fwd_we_i && fwd_rd_i != '0 && fwd_rd_i == instr.r.rs2) ?
                   fwd_data_i : rs2_data_i;

  always_comb begin
    id_ex_d           = '0;
    // Younger than a redirecting instruction
    id_ex_d.valid     = if_id_i.valid && !redirect_i.valid;
    id_ex_d.pc        = if_id_i.pc;
    id_ex_d.operand_a = rs1_val;
    id_ex_d.operand_b = rs2_val;
    id_ex_d.rd        = instr.r.rd;
    id_ex_d.alu_op    = ALU_ADD;
    case (instr.r.opcode)
      OPC_OP: begin
        id_ex_d.reg_we = 1'b1;
        case ({instr.r.funct7, instr.r.funct3})
          {F7_BASE, F3_ADD_SUB}: id_ex_d.alu_op = ALU_ADD;
          {F7_SUB, F3_ADD_SUB}:  id_ex_d.alu_op = ALU_SUB;
          {F7_BASE, F3_XOR}:     id_ex_d.alu_op = ALU_XOR;
          {F7_BASE, F3_OR}:      id_ex_d.alu_op = ALU_OR;
          {F7_BASE, F3_AND}:     id_ex_d.alu_op = ALU_AND;
          default:               id_ex_d.reg_we = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        // ADDI only, other funct3 fall to NOP
        id_ex_d.reg_we    = (instr.i.funct3 == F3_ADD_SUB);
        id_ex_d.operand_b = imm_i;
        id_ex_d.immediate = imm_i;
      end
      OPC_LUI: begin
        id_ex_d.reg_we    = 1'b1;
        id_ex_d.alu_op    = ALU_PASS_B;
        id_ex_d.operand_b = imm_u;
        id_ex_d.immediate = imm_u;
      end
      OPC_BRANCH: begin
        id_ex_d.is_branch = (instr.r.funct3 == F3_BEQ) || (instr.r.funct3 == F3_BNE);
        id_ex_d.branch_ne = (instr.r.funct3 == F3_BNE);
        id_ex_d.immediate = imm_b;
      end
      OPC_JAL: begin
        id_ex_d.reg_we    = 1'b1;
        id_ex_d.is_jal    = 1'b1;
        id_ex_d.immediate = imm_j;
      end
      default: begin
        // Unknown opcode, retires with no effect
        id_ex_d.reg_we = 1'b0;
      end
    endcase
  end

  // Payload free running, valid cleared by reset
  always_ff @(posedge clk_i) begin
    id_ex_q <= id_ex_d;
    if (!rst_n_i) begin
      id_ex_q.valid <= 1'b0;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
/*
  Instruction fetch: PC, request/grant/response sequencing with at most one
  request outstanding, and the fetch to decode register.
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module fetch_stage (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`CORE_XLEN-1:0] boot_addr_i,
  // Instruction memory
  output logic                  instr_req_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  output logic [`CORE_XLEN-1:0] instr_addr_o,
  input  logic [31:0]           instr_rdata_i,
  // Pipeline
  input  pipe_pkg::redirect_t   redirect_i,
  output pipe_pkg::if_id_t      if_id_o
);
  import pipe_pkg::*;

  // Address of the request in flight or about to go out
  logic [`CORE_XLEN-1:0] pc_q;
  logic                  pending_q;
  // Response in flight belongs to a redirected path
  logic                  discard_q;
  logic                  req_fire;
  logic                  resp_fire;
  logic                  resp_keep;
  if_id_t                if_id_q;

  // Request whenever nothing is outstanding
  assign instr_req_o  = !pending_q;
  assign instr_addr_o = pc_q;

  assign req_fire  = instr_req_o && instr_gnt_i;
  assign resp_fire = pending_q && instr_rvalid_i;
  assign resp_keep = resp_fire && !discard_q && !redirect_i.valid;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q      <= boot_addr_i;
      pending_q <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      if (req_fire) begin
        pending_q <= 1'b1;
      end else if (resp_fire) begin
        pending_q <= 1'b0;
      end
      // Old-path data still to come
      if (redirect_i.valid && (req_fire || (pending_q && !instr_rvalid_i))) begin
        discard_q <= 1'b1;
      end else if (resp_fire) begin
        discard_q <= 1'b0;
      end
      if (redirect_i.valid) begin
        pc_q <= redirect_i.target;
      end else if (resp_keep) begin
        pc_q <= pc_q + `CORE_XLEN'd4;
      end
    end
  end

  // Fetched word and its PC, valid for one cycle
  always_ff @(posedge clk_i) begin
    if (resp_fire) begin
      if_id_q.pc    <= pc_q;
      if_id_q.instr <= instr_rdata_i;
    end
    if_id_q.valid <= rst_n_i && resp_keep;
  end

  assign if_id_o = if_id_q;

  // Granted request blocks new ones through the response
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_fire |=> (!instr_req_o until_with instr_rvalid_i));

  // Address held until grant, a redirect may move it
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (instr_req_o && !instr_gnt_i && !redirect_i.valid) |=> $stable(instr_addr_o));

endmodule

`default_nettype wire

// File: design/register_file.sv
/*
  Integer register file: two combinational read ports, one write port.
  x0 stays zero because writes to it are dropped.
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module register_file (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [`CORE_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`CORE_REG_ADDR_W-1:0] raddr_b_i,
  output logic [`CORE_XLEN-1:0]       rdata_a_o,
  output logic [`CORE_XLEN-1:0]       rdata_b_o,
  input  logic                        we_i,
  input  logic [`CORE_REG_ADDR_W-1:0] waddr_i,
  input  logic [`CORE_XLEN-1:0]       wdata_i
);

  logic [`CORE_XLEN-1:0] regs_q [`CORE_NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  // Reset and the write guard keep x0 at zero
  a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((raddr_a_i == '0) |-> (rdata_a_o == '0)) and ((raddr_b_i == '0) |-> (rdata_b_o == '0)));

endmodule

`default_nettype wire

// File: design/pipe_pkg.sv
/*
  Pipeline register and side-band types between the core stages.
  Imported by the stages, the top level and the testbench retire check.
*/
`default_nettype none

`include "core_settings.svh"

package pipe_pkg;

  // Fetch to decode, one accepted response
  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    isa_pkg::instr_u       instr;
  } if_id_t;

  // Decode to execute, operands already forwarded
  typedef struct packed {
    logic                        valid;
    logic [`CORE_XLEN-1:0]       pc;
    logic [`CORE_XLEN-1:0]       operand_a;
    logic [`CORE_XLEN-1:0]       operand_b;
    logic [`CORE_XLEN-1:0]       immediate;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic                        reg_we;
    isa_pkg::alu_op_e            alu_op;
    logic                        is_branch;
    logic                        branch_ne;
    logic                        is_jal;
  } id_ex_t;

  // Execute back to fetch and decode
  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] target;
  } redirect_t;

  // One retired instruction
  typedef struct packed {
    logic                        valid;
    logic [`CORE_XLEN-1:0]       pc;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic                        we;
    logic [`CORE_XLEN-1:0]       data;
  } retire_t;

endpackage

`default_nettype wire

// File: design/isa_pkg.sv
/*
  RV32I encodings for the kept subset: opcodes, funct fields, the two
  instruction views and the ALU operation type. Imported by decode and execute.
*/
`default_nettype none

`include "core_settings.svh"

package isa_pkg;

  // Major opcodes of the kept subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // funct3 values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // funct7 values, SUB sets bit 30
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // R view, register fields
  typedef struct packed {
    logic [6:0]                  funct7;
    logic [`CORE_REG_ADDR_W-1:0] rs2;
    logic [`CORE_REG_ADDR_W-1:0] rs1;
    logic [2:0]                  funct3;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic [6:0]                  opcode;
  } r_format_t;

  // I view, source of all immediate bits
  typedef struct packed {
    logic [11:0]                 imm;
    logic [`CORE_REG_ADDR_W-1:0] rs1;
    logic [2:0]                  funct3;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic [6:0]                  opcode;
  } i_format_t;

  // One fetched word, read through either view
  typedef union packed {
    r_format_t r;
    i_format_t i;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

endpackage

`default_nettype wire

// File: design/core_settings.svh
/*
  Width and size settings shared by the mini core and its testbench.
  Include wherever a data width, register index or the NOP word is needed.
*/
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and address width
`define CORE_XLEN 32

// Register index width
`define CORE_REG_ADDR_W 5

// Architectural register count
`define CORE_NUM_REGS 32

// ADDI x0, x0, 0
// Decoded in place of empty or flushed slots
`define CORE_NOP_INSTR 32'h0000_0013

`endif
